/* rtl/icache_ctrl.sv */
`timescale 1ns/1ns

module icache_ctrl #(
    parameter int NUM_WAYS = 2
) (
    input  logic                   clk,
    input  logic                   rst,

    // fetch side
    input  logic                   i_req,
    input  icache_pkg::addr_t      i_addr,
    input  logic                   i_flush,
    output logic                   o_busy,
    output logic                   o_rvalid,
    output icache_pkg::word_t      o_rdata,

    // memory side
    output logic                   o_mem_rd,
    output icache_pkg::addr_t      o_mem_addr,
    input  icache_pkg::word_t      i_mem_rdata,
    input  logic                   i_mem_ack,

    // from way select
    input  logic                   i_hit,
    input  logic [NUM_WAYS-1:0]    i_hit_way,
    input  icache_pkg::word_t      i_hit_data,
    input  logic [NUM_WAYS-1:0]    i_victim_way,

    // to the ways
    output icache_pkg::index_t     o_rd_index,
    output icache_pkg::tag_t       o_lookup_tag,
    output logic [NUM_WAYS-1:0]    o_wr_en,
    output icache_pkg::tag_t       o_wr_tag,
    output icache_pkg::word_t      o_wr_data,
    output logic                   o_flush,

    // replacement update
    output logic                   o_touch,
    output logic [NUM_WAYS-1:0]    o_touch_way
);

    icache_pkg::ctrl_state_t state_q;
    icache_pkg::ctrl_state_t state_d;

    // latched request address
    icache_pkg::addr_t  req_addr_q;
    icache_pkg::index_t req_index;
    icache_pkg::tag_t   req_tag;
    icache_pkg::index_t in_index;

    logic accept_req;
    logic hit_done;
    logic fill_done;
    logic resp_valid;

    // requests only count while idle, flush has priority
    assign accept_req = (state_q == icache_pkg::IDLE) && i_req && !i_flush;

    assign hit_done   = (state_q == icache_pkg::LOOKUP) && i_hit;
    assign fill_done  = (state_q == icache_pkg::REFILL) && i_mem_ack;
    assign resp_valid = hit_done || fill_done;

    assign req_index = req_addr_q[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign req_tag   = req_addr_q[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign in_index  = i_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (i_flush) begin
                    state_d = icache_pkg::FLUSH;
                end else if (i_req) begin
                    state_d = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                if (i_hit) begin
                    state_d = icache_pkg::IDLE;
                end else begin
                    state_d = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                // wait as long as memory needs
                if (i_mem_ack) begin
                    state_d = icache_pkg::IDLE;
                end
            end
            icache_pkg::FLUSH: begin
                state_d = icache_pkg::IDLE;
            end
            default: begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_req) begin
            req_addr_q <= i_addr;
        end
    end

    // response pulse, one cycle after the hit or the ack
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_rvalid <= 1'b0;
        end else begin
            o_rvalid <= resp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_valid) begin
            o_rdata <= hit_done ? i_hit_data : i_mem_rdata;
        end
    end

    assign o_busy = (state_q != icache_pkg::IDLE);

    // memory read held for the whole refill
    assign o_mem_rd   = (state_q == icache_pkg::REFILL);
    assign o_mem_addr = {req_addr_q[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                         {icache_pkg::OFFSET_W{1'b0}}};

    // index from the port while idle so the read lines up with edge N
    assign o_rd_index   = (state_q == icache_pkg::IDLE) ? in_index : req_index;
    assign o_lookup_tag = req_tag;

    // fill goes to the victim on the ack edge
    assign o_wr_en   = fill_done ? i_victim_way : '0;
    assign o_wr_tag  = req_tag;
    assign o_wr_data = i_mem_rdata;

    assign o_flush = (state_q == icache_pkg::FLUSH);

    assign o_touch     = resp_valid;
    assign o_touch_way = hit_done ? i_hit_way : i_victim_way;

endmodule

/* rtl/icache_pkg.sv */
package icache_pkg;

    // address split: tag | index | byte offset
    localparam int ADDR_W   = 32;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 2;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // saturation point of the per-way age counters
    localparam int AGE_MAX  = 7;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [31:0]        word_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [2:0]         age_t;

    // controller FSM
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        FLUSH
    } ctrl_state_t;

endpackage

/* rtl/icache_top.sv */
`timescale 1ns/1ns

module icache_top #(
    parameter int NUM_WAYS = 2
) (
    input  logic                 clk,
    input  logic                 rst,

    // fetch side
    input  logic                 i_req,
    input  icache_pkg::addr_t    i_addr,
    input  logic                 i_flush,
    output logic                 o_busy,
    output logic                 o_rvalid,
    output icache_pkg::word_t    o_rdata,

    // memory side
    output logic                 o_mem_rd,
    output icache_pkg::addr_t    o_mem_addr,
    input  icache_pkg::word_t    i_mem_rdata,
    input  logic                 i_mem_ack
);

    // controller to ways
    icache_pkg::index_t rd_index;
    icache_pkg::tag_t   lookup_tag;
    logic [NUM_WAYS-1:0] wr_en;
    icache_pkg::tag_t   wr_tag;
    icache_pkg::word_t  wr_data;
    logic               flush_strobe;

    // ways to way select
    logic [NUM_WAYS-1:0]              way_hit;
    logic [NUM_WAYS-1:0]              way_valid;
    icache_pkg::word_t [NUM_WAYS-1:0] way_data;

    // way select to controller
    logic                hit;
    logic [NUM_WAYS-1:0] hit_way;
    icache_pkg::word_t   hit_data;
    logic [NUM_WAYS-1:0] victim_way;

    logic                touch;
    logic [NUM_WAYS-1:0] touch_way;

    icache_ctrl #(
        .NUM_WAYS (NUM_WAYS)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_req        (i_req),
        .i_addr       (i_addr),
        .i_flush      (i_flush),
        .o_busy       (o_busy),
        .o_rvalid     (o_rvalid),
        .o_rdata      (o_rdata),
        .o_mem_rd     (o_mem_rd),
        .o_mem_addr   (o_mem_addr),
        .i_mem_rdata  (i_mem_rdata),
        .i_mem_ack    (i_mem_ack),
        .i_hit        (hit),
        .i_hit_way    (hit_way),
        .i_hit_data   (hit_data),
        .i_victim_way (victim_way),
        .o_rd_index   (rd_index),
        .o_lookup_tag (lookup_tag),
        .o_wr_en      (wr_en),
        .o_wr_tag     (wr_tag),
        .o_wr_data    (wr_data),
        .o_flush      (flush_strobe),
        .o_touch      (touch),
        .o_touch_way  (touch_way)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        icache_way u_way (
            .clk          (clk),
            .rst          (rst),
            .i_rd_index   (rd_index),
            .i_lookup_tag (lookup_tag),
            .i_wr_en      (wr_en[g]),
            .i_wr_tag     (wr_tag),
            .i_wr_data    (wr_data),
            .i_flush      (flush_strobe),
            .o_hit        (way_hit[g]),
            .o_valid      (way_valid[g]),
            .o_data       (way_data[g])
        );
    end

    icache_way_select #(
        .NUM_WAYS (NUM_WAYS)
    ) u_way_select (
        .clk          (clk),
        .rst          (rst),
        .i_index      (rd_index),
        .i_way_hit    (way_hit),
        .i_way_valid  (way_valid),
        .i_way_data   (way_data),
        .i_touch      (touch),
        .i_touch_way  (touch_way),
        .i_flush      (flush_strobe),
        .o_hit        (hit),
        .o_hit_way    (hit_way),
        .o_hit_data   (hit_data),
        .o_victim_way (victim_way)
    );

endmodule

/* rtl/icache_way.sv */
`timescale 1ns/1ns

module icache_way (
    input  logic                 clk,
    input  logic                 rst,
    input  icache_pkg::index_t   i_rd_index,
    input  icache_pkg::tag_t     i_lookup_tag,
    input  logic                 i_wr_en,
    input  icache_pkg::tag_t     i_wr_tag,
    input  icache_pkg::word_t    i_wr_data,
    input  logic                 i_flush,
    output logic                 o_hit,
    output logic                 o_valid,
    output icache_pkg::word_t    o_data
);

    localparam int SETS = 2 ** icache_pkg::INDEX_W;

    // line storage, no reset needed on tag and data
    icache_pkg::tag_t  tag_mem  [SETS];
    icache_pkg::word_t data_mem [SETS];

    // one valid flop per set
    logic [SETS-1:0] valid_q;

    // synchronous read registers
    icache_pkg::tag_t  rd_tag_q;
    icache_pkg::word_t rd_data_q;
    logic              rd_valid_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (i_flush) begin
            valid_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_rd_index] <= 1'b1;
        end
    end

    // fill path
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_rd_index]  <= i_wr_tag;
            data_mem[i_rd_index] <= i_wr_data;
        end
    end

    // read port, sampled every cycle at the current index
    always_ff @(posedge clk) begin
        rd_tag_q  <= tag_mem[i_rd_index];
        rd_data_q <= data_mem[i_rd_index];
    end

    // valid copy follows flush so a stale hit never survives it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_valid_q <= 1'b0;
        end else if (i_flush) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[i_rd_index];
        end
    end

    // tag compare on the registered line
    assign o_hit   = rd_valid_q && (rd_tag_q == i_lookup_tag);
    assign o_valid = rd_valid_q;
    assign o_data  = rd_data_q;

endmodule

/* rtl/icache_way_select.sv */
`timescale 1ns/1ns

module icache_way_select #(
    parameter int NUM_WAYS = 2
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  icache_pkg::index_t                     i_index,
    input  logic [NUM_WAYS-1:0]                    i_way_hit,
    input  logic [NUM_WAYS-1:0]                    i_way_valid,
    input  icache_pkg::word_t [NUM_WAYS-1:0]       i_way_data,
    input  logic                                   i_touch,
    input  logic [NUM_WAYS-1:0]                    i_touch_way,
    input  logic                                   i_flush,
    output logic                                   o_hit,
    output logic [NUM_WAYS-1:0]                    o_hit_way,
    output icache_pkg::word_t                      o_hit_data,
    output logic [NUM_WAYS-1:0]                    o_victim_way
);

    localparam int SETS = 2 ** icache_pkg::INDEX_W;

    // age per way per set
    icache_pkg::age_t [NUM_WAYS-1:0] age_q [SETS];
    icache_pkg::age_t [NUM_WAYS-1:0] cur_age;

    logic                found_invalid;
    logic [NUM_WAYS-1:0] invalid_way;
    logic [NUM_WAYS-1:0] oldest_way;
    icache_pkg::age_t    oldest_age;

    // at most one way can match a given tag
    assign o_hit     = |i_way_hit;
    assign o_hit_way = i_way_hit;

    always_comb begin
        o_hit_data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (i_way_hit[w]) begin
                o_hit_data = o_hit_data | i_way_data[w];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                age_q[s] <= '0;
            end
        end else if (i_flush) begin
            for (int s = 0; s < SETS; s++) begin
                age_q[s] <= '0;
            end
        end else if (i_touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (i_touch_way[w]) begin
                    age_q[i_index][w] <= '0;
                end else if (age_q[i_index][w] != icache_pkg::age_t'(icache_pkg::AGE_MAX)) begin
                    age_q[i_index][w] <= age_q[i_index][w] + 1'b1;
                end
            end
        end
    end

    assign cur_age = age_q[i_index];

    // victim: first empty way, else the oldest, lowest number on ties
    always_comb begin
        found_invalid = 1'b0;
        invalid_way   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!i_way_valid[w] && !found_invalid) begin
                invalid_way[w] = 1'b1;
                found_invalid  = 1'b1;
            end
        end

        oldest_way    = '0;
        oldest_way[0] = 1'b1;
        oldest_age    = cur_age[0];
        for (int w = 1; w < NUM_WAYS; w++) begin
            if (cur_age[w] > oldest_age) begin
                oldest_way    = '0;
                oldest_way[w] = 1'b1;
                oldest_age    = cur_age[w];
            end
        end

        o_victim_way = found_invalid ? invalid_way : oldest_way;
    end

endmodule

/* src.f */
rtl/icache_pkg.sv
rtl/icache_way.sv
rtl/icache_way_select.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/tb_mem_model.sv
tb/tb_icache.sv

/* tb/tb_icache.sv */
`timescale 1ns/1ns

module tb_icache;

    localparam int          NUM_WAYS       = 2;
    localparam int          SETS           = 2 ** icache_pkg::INDEX_W;
    localparam logic [31:0] DATA_KEY       = 32'h5A5A_C3C3;
    localparam int          NUM_REQUESTS   = 215;
    localparam int          TIMEOUT_CYCLES = 40 * NUM_REQUESTS + 200;

    logic              clk;
    logic              rst;
    logic              req;
    icache_pkg::addr_t addr;
    logic              flush;
    logic              busy;
    logic              rvalid;
    icache_pkg::word_t rdata;
    logic              mem_rd;
    icache_pkg::addr_t mem_addr;
    icache_pkg::word_t mem_rdata;
    logic              mem_ack;
    int                mem_reads;

    int errors = 0;
    int checks = 0;
    int cycle_cnt = 0;
    int rand_seed = 89637;
    int model_reads = 0;

    // what the last fetch saw on the ports
    int                last_lat;
    logic              last_mem_seen;
    icache_pkg::addr_t last_mem_addr;

    // reference model state
    logic             m_valid [SETS][NUM_WAYS];
    icache_pkg::tag_t m_tag   [SETS][NUM_WAYS];
    int               m_age   [SETS][NUM_WAYS];
    icache_pkg::tag_t evicted_tag;

    icache_pkg::index_t rand_sets [4] = '{6'd3, 6'd17, 6'd40, 6'd63};
    icache_pkg::tag_t   rand_tags [4] = '{24'h000001, 24'h0ABCDE, 24'h123456, 24'hFFFFF0};

    icache_top #(.NUM_WAYS(NUM_WAYS)) DUT (
        .clk(clk), .rst(rst), .i_req(req), .i_addr(addr), .i_flush(flush),
        .o_busy(busy), .o_rvalid(rvalid), .o_rdata(rdata),
        .o_mem_rd(mem_rd), .o_mem_addr(mem_addr),
        .i_mem_rdata(mem_rdata), .i_mem_ack(mem_ack)
    );

    tb_mem_model #(.DATA_KEY(DATA_KEY), .MAX_DELAY(5), .SEED(89637)) u_mem (
        .clk(clk), .rst(rst), .i_mem_rd(mem_rd), .i_mem_addr(mem_addr),
        .o_mem_rdata(mem_rdata), .o_mem_ack(mem_ack), .o_read_count(mem_reads)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_word(input icache_pkg::word_t got, input icache_pkg::word_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input icache_pkg::addr_t got, input icache_pkg::addr_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic icache_pkg::addr_t make_addr(input icache_pkg::tag_t tg,
                                                    input icache_pkg::index_t idx,
                                                    input logic [1:0] off);
        return {tg, idx, off};
    endfunction

    function automatic icache_pkg::addr_t word_align(input icache_pkg::addr_t a);
        return a & ~32'h3;
    endfunction

    // memory returns the aligned address xor the key
    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
        return word_align(a) ^ DATA_KEY;
    endfunction

    task automatic model_flush();
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_age[s][w]   = 0;
            end
        end
    endtask

    // lookup, fill and age update of one access
    task automatic model_access(input icache_pkg::addr_t a, output bit miss);
        icache_pkg::index_t idx;
        icache_pkg::tag_t   tg;
        int                 way;
        idx = a[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
        tg  = a[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                way = w;
            end
        end
        miss = (way < 0);
        if (miss) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (!m_valid[idx][w] && way < 0) begin
                    way = w;
                end
            end
            if (way < 0) begin
                // all valid: oldest way, lowest number on a tie
                way = 0;
                for (int w = 1; w < NUM_WAYS; w++) begin
                    if (m_age[idx][w] > m_age[idx][way]) begin
                        way = w;
                    end
                end
                evicted_tag = m_tag[idx][way];
            end
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way]   = tg;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (w == way) begin
                m_age[idx][w] = 0;
            end else if (m_age[idx][w] < icache_pkg::AGE_MAX) begin
                m_age[idx][w]++;
            end
        end
    endtask

    // one request on the fetch port, returns the word
    task automatic dut_fetch(input icache_pkg::addr_t a, output icache_pkg::word_t data);
        do begin
            @(posedge clk);
        end while (busy);
        req  <= 1'b1;
        addr <= a;
        @(posedge clk);
        req           <= 1'b0;
        last_lat      = 0;
        last_mem_seen = 1'b0;
        do begin
            @(posedge clk);
            last_lat++;
            if (mem_rd) begin
                last_mem_seen = 1'b1;
                last_mem_addr = mem_addr;
            end
        end while (!rvalid);
        data = rdata;
    endtask

    task automatic fetch_and_check(input icache_pkg::addr_t a);
        icache_pkg::word_t got;
        int                reads_before;
        bit                miss;
        reads_before = mem_reads;
        model_access(a, miss);
        dut_fetch(a, got);
        check_word(got, expected_word(a), "fetch data");
        check_count(mem_reads - reads_before, miss ? 1 : 0, "memory reads of one fetch");
        if (miss) begin
            model_reads++;
        end
    endtask

    task automatic do_flush();
        int busy_cycles;
        do begin
            @(posedge clk);
        end while (busy);
        flush <= 1'b1;
        @(posedge clk);
        flush       <= 1'b0;
        busy_cycles = 0;
        @(posedge clk);
        while (busy) begin
            busy_cycles++;
            @(posedge clk);
        end
        check_count(busy_cycles, 1, "busy cycles of a flush");
        model_flush();
    endtask

    task automatic run_reset_test();
        @(posedge clk);
        check_flag(busy, 1'b0, "o_busy after reset");
        check_flag(rvalid, 1'b0, "o_rvalid after reset");
        check_flag(mem_rd, 1'b0, "o_mem_rd after reset");
        fetch_and_check(32'h0000_1237);
        check_flag(last_mem_seen, 1'b1, "memory read on first fetch");
        check_addr(last_mem_addr, 32'h0000_1234, "o_mem_addr of first fetch");
        check_count(mem_reads, 1, "memory reads after first fetch");
    endtask

    task automatic run_hit_test();
        fetch_and_check(32'h0000_1235);
        check_count(last_lat, 2, "hit latency");
        check_flag(last_mem_seen, 1'b0, "memory read on a hit");
    endtask

    task automatic run_fill_test();
        for (int k = 0; k < NUM_WAYS; k++) begin
            fetch_and_check(make_addr(24'h00A000 + k, 6'd5, 2'd0));
        end
        for (int k = 0; k < NUM_WAYS; k++) begin
            fetch_and_check(make_addr(24'h00A000 + k, 6'd5, 2'd2));
        end
    endtask

    task automatic run_replace_test();
        icache_pkg::tag_t tg;
        fetch_and_check(make_addr(24'h00A000, 6'd5, 2'd1));
        fetch_and_check(make_addr(24'h00A000 + NUM_WAYS, 6'd5, 2'd0));
        // survivors first, the evicted tag last
        for (int k = 0; k <= NUM_WAYS; k++) begin
            tg = 24'h00A000 + k;
            if (tg != evicted_tag) begin
                fetch_and_check(make_addr(tg, 6'd5, 2'd3));
            end
        end
        fetch_and_check(make_addr(evicted_tag, 6'd5, 2'd0));
    endtask

    task automatic run_flush_test();
        int               reads_before;
        icache_pkg::tag_t resident [NUM_WAYS];
        // tags held in set 5 before the flush
        for (int w = 0; w < NUM_WAYS; w++) begin
            resident[w] = m_tag[5][w];
        end
        reads_before = mem_reads;
        do_flush();
        fetch_and_check(32'h0000_1234);
        for (int w = 0; w < NUM_WAYS; w++) begin
            fetch_and_check(make_addr(resident[w], 6'd5, 2'd0));
        end
        check_count(mem_reads - reads_before, 1 + NUM_WAYS, "memory reads after flush");
    endtask

    task automatic run_random_test();
        logic [31:0] r;
        for (int i = 0; i < 200; i++) begin
            r = $random(rand_seed);
            fetch_and_check(make_addr(rand_tags[r[3:2]], rand_sets[r[1:0]], r[5:4]));
        end
        check_count(mem_reads, model_reads, "total memory reads");
    endtask

    initial begin
        rst   = 1'b0;
        req   = 1'b0;
        addr  = '0;
        flush = 1'b0;
        model_flush();
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        run_reset_test();
        run_hit_test();
        run_fill_test();
        run_replace_test();
        run_flush_test();
        run_random_test();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ns

module tb_mem_model #(
    parameter logic [31:0] DATA_KEY  = 32'h5A5A_C3C3,
    parameter int          MAX_DELAY = 5,
    parameter int          SEED      = 89637
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_mem_rd,
    input  icache_pkg::addr_t i_mem_addr,
    output icache_pkg::word_t o_mem_rdata,
    output logic              o_mem_ack,
    output int                o_read_count
);

    int   seed;
    int   wait_cnt;
    logic serving;

    initial begin
        seed         = SEED;
        o_mem_ack    = 1'b0;
        o_mem_rdata  = '0;
        o_read_count = 0;
        serving      = 1'b0;
        wait_cnt     = 0;
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_mem_ack    <= 1'b0;
            o_mem_rdata  <= '0;
            o_read_count <= 0;
            serving      <= 1'b0;
            wait_cnt     <= 0;
        end else begin
            o_mem_ack <= 1'b0;
            if (serving) begin
                if (wait_cnt == 0) begin
                    o_mem_ack    <= 1'b1;
                    o_mem_rdata  <= i_mem_addr ^ DATA_KEY;
                    o_read_count <= o_read_count + 1;
                    serving      <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (i_mem_rd && !o_mem_ack) begin
                // read still high on the ack edge, so skip that one
                serving  <= 1'b1;
                wait_cnt <= {$random(seed)} % (MAX_DELAY + 1);
            end
        end
    end

endmodule
